//--- src/isa_pkg.sv
package isa_pkg;

    localparam int XLEN  = 32;
    localparam int NREGS = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [XLEN-1:0] word_t;

    // field positions in the instruction word
    localparam int RD_LO  = 0;
    localparam int RJ_LO  = 5;
    localparam int RK_LO  = 10;
    localparam int I12_LO = 10;
    localparam int I16_LO = 10;
    localparam int I20_LO = 5;
    localparam int OP5_LO = 15;
    localparam int OP2_LO = 20;
    localparam int OP4_LO = 22;
    localparam int OP6_LO = 26;

    localparam reg_addr_t RA_REG = 5'd1;  // link register for bl

    // major opcode, inst[31:26]
    localparam logic [5:0] OP6_ALU   = 6'h00;
    localparam logic [5:0] OP6_LU12I = 6'h05;  // also needs inst[25] clear
    localparam logic [5:0] OP6_JIRL  = 6'h13;
    localparam logic [5:0] OP6_B     = 6'h14;
    localparam logic [5:0] OP6_BL    = 6'h15;
    localparam logic [5:0] OP6_BEQ   = 6'h16;
    localparam logic [5:0] OP6_BNE   = 6'h17;
    localparam logic [5:0] OP6_BLT   = 6'h18;
    localparam logic [5:0] OP6_BLTU  = 6'h1a;

    // minor opcodes under OP6_ALU
    localparam logic [3:0] OP4_3R   = 4'h0;
    localparam logic [3:0] OP4_ADDI = 4'ha;
    localparam logic [3:0] OP4_ANDI = 4'hd;
    localparam logic [3:0] OP4_ORI  = 4'he;
    localparam logic [1:0] OP2_3R   = 2'h1;

    localparam logic [4:0] OP5_ADD  = 5'h00;
    localparam logic [4:0] OP5_SUB  = 5'h02;
    localparam logic [4:0] OP5_SLT  = 5'h04;
    localparam logic [4:0] OP5_SLTU = 5'h05;
    localparam logic [4:0] OP5_AND  = 5'h09;
    localparam logic [4:0] OP5_OR   = 5'h0a;
    localparam logic [4:0] OP5_XOR  = 5'h0b;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_LUI,
        ALU_NONE
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_SI12,
        IMM_UI12,
        IMM_SI20_HI,
        IMM_FOUR,
        IMM_NONE
    } imm_kind_e;

    // BR_JIRL is unconditional but targets rj plus offset
    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_LTU,
        BR_ALWAYS,
        BR_JIRL
    } br_kind_e;

endpackage

//--- src/pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_bus_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_bus_t;

    typedef struct packed {
        alu_op_e   alu_op;
        word_t     imm;
        imm_kind_e imm_kind;
        word_t     br_offs;      // already shifted left by 2
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      rkd_is_rd;    // second read port takes rd
        br_kind_e  br_kind;
        logic      gr_we;
        reg_addr_t dest;
        logic      need_rj;
        logic      need_rkd;
        logic      ine;
    } dec_ctrl_t;

    typedef struct packed {
        alu_op_e   alu_op;
        word_t     src1;
        word_t     src2;
        word_t     rkd_value;
        reg_addr_t dest;
        logic      gr_we;
        word_t     pc;
        logic      ine;
    } exec_bus_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_bus_t;

endpackage

//--- src/id_latch.sv
`timescale 1ns/1ps

module id_latch
    import pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       fetch_valid,
    input  fetch_bus_t fetch_bus,
    output logic       id_allowin,

    input  logic       ex_allowin,
    input  logic       br_cond,
    output logic       exec_valid,
    output logic       redirect_taken,
    output fetch_bus_t id_fetch
);

    logic       valid_q;
    logic       handoff;
    fetch_bus_t fetch_q;

    // decode never stalls, only execute pushes back
    assign handoff        = valid_q && ex_allowin;
    assign exec_valid     = valid_q;
    assign id_allowin     = !valid_q || handoff;
    assign redirect_taken = handoff && br_cond;
    assign id_fetch       = fetch_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (redirect_taken) begin
            valid_q <= 1'b0;  // squash the fetch accepted alongside
        end else if (id_allowin) begin
            valid_q <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && id_allowin) begin
            fetch_q <= fetch_bus;
        end
    end

endmodule

//--- src/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  word_t     inst,
    output dec_ctrl_t ctrl
);

    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [1:0]  op2;
    logic [4:0]  op5;
    reg_addr_t   rd;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    logic        is_3r;
    logic        is_link;
    logic        far_jump;
    logic        cond_br;
    logic        ine;
    alu_op_e     alu_op;
    imm_kind_e   imm_kind;
    br_kind_e    br_kind;
    word_t       imm;

    assign op6 = inst[OP6_LO +: 6];
    assign op4 = inst[OP4_LO +: 4];
    assign op2 = inst[OP2_LO +: 2];
    assign op5 = inst[OP5_LO +: 5];
    assign rd  = inst[RD_LO +: 5];
    assign i12 = inst[I12_LO +: 12];
    assign i16 = inst[I16_LO +: 16];
    assign i20 = inst[I20_LO +: 20];
    assign i26 = {inst[9:0], inst[25:10]};  // offs[25:16] sits in the low bits

    assign is_3r = (op4 == OP4_3R) && (op2 == OP2_3R);

    always_comb begin
        alu_op   = ALU_NONE;
        imm_kind = IMM_NONE;
        br_kind  = BR_NONE;
        case (op6)
            OP6_ALU: begin
                if (is_3r) begin
                    case (op5)
                        OP5_ADD:  alu_op = ALU_ADD;
                        OP5_SUB:  alu_op = ALU_SUB;
                        OP5_SLT:  alu_op = ALU_SLT;
                        OP5_SLTU: alu_op = ALU_SLTU;
                        OP5_AND:  alu_op = ALU_AND;
                        OP5_OR:   alu_op = ALU_OR;
                        OP5_XOR:  alu_op = ALU_XOR;
                        default:  alu_op = ALU_NONE;
                    endcase
                end else begin
                    case (op4)
                        OP4_ADDI: begin
                            alu_op   = ALU_ADD;
                            imm_kind = IMM_SI12;
                        end
                        OP4_ANDI: begin
                            alu_op   = ALU_AND;
                            imm_kind = IMM_UI12;
                        end
                        OP4_ORI: begin
                            alu_op   = ALU_OR;
                            imm_kind = IMM_UI12;
                        end
                        default: alu_op = ALU_NONE;
                    endcase
                end
            end
            OP6_LU12I: begin
                if (!inst[25]) begin
                    alu_op   = ALU_LUI;
                    imm_kind = IMM_SI20_HI;
                end
            end
            OP6_JIRL: begin
                alu_op   = ALU_ADD;  // rd = pc + 4
                imm_kind = IMM_FOUR;
                br_kind  = BR_JIRL;
            end
            OP6_BL: begin
                alu_op   = ALU_ADD;
                imm_kind = IMM_FOUR;
                br_kind  = BR_ALWAYS;
            end
            OP6_B:    br_kind = BR_ALWAYS;
            OP6_BEQ:  br_kind = BR_EQ;
            OP6_BNE:  br_kind = BR_NE;
            OP6_BLT:  br_kind = BR_LT;
            OP6_BLTU: br_kind = BR_LTU;
            default:  br_kind = BR_NONE;
        endcase
    end

    always_comb begin
        case (imm_kind)
            IMM_SI12:    imm = {{20{i12[11]}}, i12};
            IMM_UI12:    imm = {20'b0, i12};
            IMM_SI20_HI: imm = {i20, 12'b0};
            IMM_FOUR:    imm = 32'd4;
            default:     imm = '0;
        endcase
    end

    assign ine      = (alu_op == ALU_NONE) && (br_kind == BR_NONE);
    assign is_link  = (imm_kind == IMM_FOUR);
    assign far_jump = (br_kind == BR_ALWAYS);  // b and bl
    assign cond_br  = (br_kind inside {BR_EQ, BR_NE, BR_LT, BR_LTU});

    assign ctrl.alu_op      = alu_op;
    assign ctrl.imm         = imm;
    assign ctrl.imm_kind    = imm_kind;
    assign ctrl.br_offs     = far_jump ? {{4{i26[25]}}, i26, 2'b00}
                                       : {{14{i16[15]}}, i16, 2'b00};
    assign ctrl.src1_is_pc  = is_link;
    assign ctrl.src2_is_imm = (imm_kind != IMM_NONE);
    assign ctrl.rkd_is_rd   = cond_br;
    assign ctrl.br_kind     = br_kind;
    assign ctrl.gr_we       = !ine && ((br_kind == BR_NONE) || is_link);
    assign ctrl.dest        = (op6 == OP6_BL) ? RA_REG : rd;
    assign ctrl.need_rj     = !ine && !far_jump && (alu_op != ALU_LUI);
    // three-register ALU ops and compare branches read the second port
    assign ctrl.need_rkd    = (!ine && (imm_kind == IMM_NONE) && (br_kind == BR_NONE))
                              || cond_br;
    assign ctrl.ine         = ine;

endmodule

//--- src/regfile.sv
`timescale 1ns/1ps

module regfile
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int DEPTH = NREGS
) (
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2,
    input  wb_bus_t   wb
);

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wb.we && (wb.waddr != '0)) begin
            mem[wb.waddr] <= wb.wdata;
        end
    end

    // r0 is hardwired, a same-cycle writeback wins over the array
    assign rdata1 = (raddr1 == '0)                     ? '0       :
                    (wb.we && (wb.waddr == raddr1))    ? wb.wdata :
                                                         mem[raddr1];
    assign rdata2 = (raddr2 == '0)                     ? '0       :
                    (wb.we && (wb.waddr == raddr2))    ? wb.wdata :
                                                         mem[raddr2];

endmodule

//--- src/operand_issue.sv
`timescale 1ns/1ps

module operand_issue
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  fetch_bus_t fetch,
    input  dec_ctrl_t  ctrl,
    input  word_t      rj_value,
    input  word_t      rkd_value,
    output logic       br_cond,
    output word_t      br_target,
    output exec_bus_t  exec_bus
);

    word_t src1;
    word_t src2;
    word_t target_base;
    logic  rj_eq;
    logic  rj_lt;
    logic  rj_ltu;

    assign src1 = ctrl.src1_is_pc  ? fetch.pc : rj_value;
    assign src2 = ctrl.src2_is_imm ? ctrl.imm : rkd_value;

    assign rj_eq  = (rj_value == rkd_value);
    assign rj_lt  = ($signed(rj_value) < $signed(rkd_value));
    assign rj_ltu = (rj_value < rkd_value);

    always_comb begin
        case (ctrl.br_kind)
            BR_EQ:     br_cond = rj_eq;
            BR_NE:     br_cond = !rj_eq;
            BR_LT:     br_cond = rj_lt;
            BR_LTU:    br_cond = rj_ltu;
            BR_ALWAYS: br_cond = 1'b1;
            BR_JIRL:   br_cond = 1'b1;
            default:   br_cond = 1'b0;
        endcase
    end

    // jirl is register relative, everything else pc relative
    assign target_base = (ctrl.br_kind == BR_JIRL) ? rj_value : fetch.pc;
    assign br_target   = target_base + ctrl.br_offs;

    assign exec_bus.alu_op    = ctrl.alu_op;
    assign exec_bus.src1      = src1;
    assign exec_bus.src2      = src2;
    assign exec_bus.rkd_value = rkd_value;
    assign exec_bus.dest      = ctrl.dest;
    assign exec_bus.gr_we     = ctrl.gr_we;
    assign exec_bus.pc        = fetch.pc;
    assign exec_bus.ine       = ctrl.ine;

endmodule

//--- src/id_stage.sv
`timescale 1ns/1ps

module id_stage
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int RF_DEPTH = NREGS
) (
    input  logic          clk,
    input  logic          rst_n,

    input  logic          fetch_valid,
    input  fetch_bus_t    fetch_bus,
    output logic          id_allowin,

    input  logic          ex_allowin,
    output logic          exec_valid,
    output exec_bus_t     exec_bus,

    input  wb_bus_t       wb_bus,
    output redirect_bus_t redirect
);

    fetch_bus_t id_fetch;
    dec_ctrl_t  ctrl;
    reg_addr_t  raddr1;
    reg_addr_t  raddr2;
    word_t      rj_value;
    word_t      rkd_value;
    word_t      br_target;
    logic       br_cond;
    logic       redirect_taken;

    // unused ports park on r0
    assign raddr1 = ctrl.need_rj ? id_fetch.inst[RJ_LO +: 5] : '0;
    assign raddr2 = !ctrl.need_rkd ? '0                        :
                    ctrl.rkd_is_rd ? id_fetch.inst[RD_LO +: 5] :
                                     id_fetch.inst[RK_LO +: 5];

    assign redirect.taken  = redirect_taken;
    assign redirect.target = br_target;

    id_latch u_latch (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_valid    (fetch_valid),
        .fetch_bus      (fetch_bus),
        .id_allowin     (id_allowin),
        .ex_allowin     (ex_allowin),
        .br_cond        (br_cond),
        .exec_valid     (exec_valid),
        .redirect_taken (redirect_taken),
        .id_fetch       (id_fetch)
    );

    inst_decoder u_decoder (
        .inst (id_fetch.inst),
        .ctrl (ctrl)
    );

    regfile #(
        .DEPTH (RF_DEPTH)
    ) u_regfile (
        .clk    (clk),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rj_value),
        .rdata2 (rkd_value),
        .wb     (wb_bus)
    );

    operand_issue u_issue (
        .fetch     (id_fetch),
        .ctrl      (ctrl),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_cond   (br_cond),
        .br_target (br_target),
        .exec_bus  (exec_bus)
    );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;  // released just after an edge
    end

endmodule

//--- bench/id_stage_properties.sv
`timescale 1ns/1ps

module id_stage_properties
    import pipe_pkg::*;
(
    input logic          clk,
    input logic          rst_n,
    input logic          ex_allowin,
    input logic          exec_valid,
    input exec_bus_t     exec_bus,
    input redirect_bus_t redirect
);

    // held bundle may not move while execute is full
    a_hold_under_backpressure: assert property (
        @(posedge clk) disable iff (!rst_n)
        exec_valid && !ex_allowin |=> exec_valid && $stable(exec_bus)
    ) else $error("bundle changed under back-pressure");

    // a taken branch leaves the stage empty behind it
    a_redirect_on_handoff: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect.taken |-> exec_valid && ex_allowin ##1 !exec_valid
    ) else $error("redirect taken without a handoff or without a squash");

    a_empty_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !exec_valid
    ) else $error("exec_valid high right after reset");

endmodule

bind id_stage id_stage_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .ex_allowin (ex_allowin),
    .exec_valid (exec_valid),
    .exec_bus   (exec_bus),
    .redirect   (redirect)
);

//--- bench/tb_top.sv
`timescale 1ns/1ps

module tb_top
    import isa_pkg::*;
    import pipe_pkg::*;
;

    localparam word_t RESET_PC = 32'h1c00_0000;

    logic          clk;
    logic          rst_n;
    logic          fetch_valid;
    fetch_bus_t    fetch_bus;
    logic          id_allowin;
    logic          ex_allowin;
    logic          exec_valid;
    exec_bus_t     exec_bus;
    wb_bus_t       wb_bus;
    redirect_bus_t redirect;

    word_t      model [NREGS];  // architectural view of the register file
    fetch_bus_t exp_q [$];
    string      test_name;
    integer     seed;
    word_t      pc;
    logic       bp_on;
    int         issued;
    int         cycles;

    tb_clock #(.PERIOD(10), .RESET_CYCLES(4)) u_clock (.clk(clk), .rst_n(rst_n));

    id_stage #(.RF_DEPTH(NREGS)) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_bus   (fetch_bus),
        .id_allowin  (id_allowin),
        .ex_allowin  (ex_allowin),
        .exec_valid  (exec_valid),
        .exec_bus    (exec_bus),
        .wb_bus      (wb_bus),
        .redirect    (redirect)
    );

    function automatic word_t enc_3r(logic [4:0] op5, reg_addr_t rd, reg_addr_t rj, reg_addr_t rk);
        return {6'h00, 4'h0, 2'h1, op5, rk, rj, rd};
    endfunction

    function automatic word_t enc_i12(logic [3:0] op4, logic [11:0] i12, reg_addr_t rj,
                                      reg_addr_t rd);
        return {6'h00, op4, i12, rj, rd};
    endfunction

    function automatic word_t enc_br(logic [5:0] op6, logic [15:0] offs, reg_addr_t rj,
                                     reg_addr_t rd);
        return {op6, offs, rj, rd};
    endfunction

    // expected bundle and redirect straight from the ISA rules
    function automatic exec_bus_t ref_bundle(input word_t inst, input word_t ipc,
                                             input word_t regs [NREGS],
                                             output redirect_bus_t rexp);
        exec_bus_t e;
        word_t     rjv;
        word_t     rkv;
        word_t     rdv;
        word_t     off16;
        word_t     off26;
        logic      known;
        e = '0;
        e.alu_op = ALU_NONE;
        e.dest = inst[4:0];
        e.pc = ipc;
        e.ine = 1'b1;
        rexp = '0;
        rjv = regs[inst[9:5]];
        rkv = regs[inst[14:10]];
        rdv = regs[inst[4:0]];
        off16 = {{14{inst[25]}}, inst[25:10], 2'b00};
        off26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        case (inst[31:26])
            6'h00: begin
                if (inst[25:20] == 6'b0000_01) begin
                    known = 1'b1;
                    case (inst[19:15])
                        5'h00: e.alu_op = ALU_ADD;
                        5'h02: e.alu_op = ALU_SUB;
                        5'h04: e.alu_op = ALU_SLT;
                        5'h05: e.alu_op = ALU_SLTU;
                        5'h09: e.alu_op = ALU_AND;
                        5'h0a: e.alu_op = ALU_OR;
                        5'h0b: e.alu_op = ALU_XOR;
                        default: known = 1'b0;
                    endcase
                    if (known) begin
                        e.src1 = rjv;
                        e.src2 = rkv;
                        e.rkd_value = rkv;
                        e.gr_we = 1'b1;
                        e.ine = 1'b0;
                    end
                end else if (inst[25:22] inside {4'ha, 4'hd, 4'he}) begin
                    e.src1 = rjv;
                    e.gr_we = 1'b1;
                    e.ine = 1'b0;
                    if (inst[25:22] == 4'ha) begin
                        e.alu_op = ALU_ADD;
                        e.src2 = {{20{inst[21]}}, inst[21:10]};
                    end else begin
                        e.alu_op = (inst[25:22] == 4'hd) ? ALU_AND : ALU_OR;
                        e.src2 = {20'b0, inst[21:10]};
                    end
                end
            end
            6'h05: begin
                if (!inst[25]) begin
                    e.alu_op = ALU_LUI;
                    e.src2 = {inst[24:5], 12'b0};
                    e.gr_we = 1'b1;
                    e.ine = 1'b0;
                end
            end
            6'h13, 6'h15: begin  // jirl and bl link pc + 4
                e.alu_op = ALU_ADD;
                e.src1 = ipc;
                e.src2 = 32'd4;
                e.gr_we = 1'b1;
                e.ine = 1'b0;
                rexp.taken = 1'b1;
                if (inst[31:26] == 6'h13) begin
                    rexp.target = rjv + off16;
                end else begin
                    e.dest = RA_REG;
                    rexp.target = ipc + off26;
                end
            end
            6'h14: begin
                e.ine = 1'b0;
                rexp.taken = 1'b1;
                rexp.target = ipc + off26;
            end
            6'h16, 6'h17, 6'h18, 6'h1a: begin
                e.src1 = rjv;
                e.src2 = rdv;
                e.rkd_value = rdv;
                e.ine = 1'b0;
                case (inst[31:26])
                    6'h16: rexp.taken = (rjv == rdv);
                    6'h17: rexp.taken = (rjv != rdv);
                    6'h18: rexp.taken = ($signed(rjv) < $signed(rdv));
                    default: rexp.taken = (rjv < rdv);
                endcase
                rexp.target = ipc + off16;
            end
            default: ;
        endcase
        return e;
    endfunction

    task automatic check_exec(string name, exec_bus_t exp, exec_bus_t act);
        if (exp !== act) begin
            $display("[FAIL] %s: exec_bus expected %h, actual %h", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1, "exec_bus mismatch");
        end
    endtask

    task automatic check_redirect(string name, redirect_bus_t exp, redirect_bus_t act);
        // target only matters when taken
        if ((exp.taken !== act.taken) || (exp.taken && (exp.target !== act.target))) begin
            $display("[FAIL] %s: redirect expected %h, actual %h", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1, "redirect mismatch");
        end
    endtask

    always @(posedge clk) begin
        if (wb_bus.we && (wb_bus.waddr != 5'd0)) begin
            model[wb_bus.waddr] <= wb_bus.wdata;
        end
    end

    // compare at the falling edge, inputs settled since posedge + 1
    always @(negedge clk) begin
        fetch_bus_t    ent;
        word_t         view [NREGS];
        exec_bus_t     e_exp;
        redirect_bus_t r_exp;
        if (rst_n && exec_valid && ex_allowin) begin
            if (exp_q.size() == 0) begin
                $display("a bundle left decode while none was expected (%s)", test_name);
                $display("SIMULATION FAILED");
                $fatal(1, "unexpected bundle");
            end else begin
                ent = exp_q.pop_front();
                view = model;
                if (wb_bus.we) begin
                    view[wb_bus.waddr] = wb_bus.wdata;  // same-cycle write-through
                end
                view[0] = '0;
                e_exp = ref_bundle(ent.inst, ent.pc, view, r_exp);
                check_exec(test_name, e_exp, exec_bus);
                check_redirect(test_name, r_exp, redirect);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * issued + 100) begin
            $display("timeout: run went past %0d cycles", 40 * issued + 100);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic drive_backpressure();
        ex_allowin = bp_on ? (($random(seed) & 3) != 0) : 1'b1;
    endtask

    task automatic write_reg(reg_addr_t addr, word_t data);
        wb_bus.we = 1'b1;
        wb_bus.waddr = addr;
        wb_bus.wdata = data;
        @(posedge clk);
        #1 wb_bus.we = 1'b0;
    endtask

    // present one word until it is taken, squashed ones are not expected
    task automatic issue(word_t inst);
        logic done;
        done = 1'b0;
        issued++;
        fetch_valid = 1'b1;
        fetch_bus.pc = pc;
        fetch_bus.inst = inst;
        while (!done) begin
            @(negedge clk);
            if (id_allowin) begin
                done = 1'b1;
                if (!redirect.taken) begin
                    exp_q.push_back(fetch_bus);
                end
            end
            @(posedge clk);
            #1 drive_backpressure();
        end
        fetch_valid = 1'b0;
        pc = pc + 32'd4;
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || exec_valid) begin
            @(posedge clk);
            #1 drive_backpressure();
        end
    endtask

    function automatic word_t random_kept();
        logic [4:0] ops [7];
        int         sel;
        ops = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h09, 5'h0a, 5'h0b};
        sel = ($random(seed) & 32'h7fff_ffff) % 4;
        case (sel)
            0: return enc_3r(ops[($random(seed) & 32'h7fff_ffff) % 7], 5'($random(seed)),
                             5'($random(seed)), 5'($random(seed)));
            1: return enc_i12(4'ha, 12'($random(seed)), 5'($random(seed)), 5'($random(seed)));
            2: return enc_br(6'h16 + 6'(($random(seed) & 32'h7fff_ffff) % 3),
                             16'($random(seed)), 5'($random(seed)), 5'($random(seed)));
            default: return $random(seed);  // mostly undefined words
        endcase
    endfunction

    initial begin
        seed = 32'h10c3;
        fetch_valid = 1'b0;
        fetch_bus = '0;
        ex_allowin = 1'b1;
        wb_bus = '0;
        bp_on = 1'b0;
        pc = RESET_PC;
        issued = 0;
        cycles = 0;
        model[0] = '0;
        test_name = "setup";
        @(posedge rst_n);
        @(posedge clk);
        #1;
        for (int r = 1; r < NREGS; r++) begin
            write_reg(5'(r), $random(seed));
        end
        write_reg(5'd11, model[10]);  // equal pair for beq

        test_name = "alu_rr";
        for (int i = 0; i < 20; i++) begin
            issue(enc_3r(5'h00 + 5'(i % 12), 5'($random(seed)),
                         5'($random(seed)), 5'($random(seed))));
        end
        drain();

        test_name = "alu_imm";
        issue(enc_i12(4'ha, 12'hfff, 5'd3, 5'd4));
        issue(enc_i12(4'hd, 12'h8f0, 5'd5, 5'd6));
        issue(enc_i12(4'he, 12'h801, 5'd7, 5'd8));
        issue({6'h05, 1'b0, 20'hfedcb, 5'd9});
        drain();

        test_name = "branch";
        issue(enc_br(6'h16, 16'h0010, 5'd10, 5'd11));  // taken, next is squashed
        issue(enc_3r(5'h00, 5'd2, 5'd3, 5'd4));
        issue(enc_br(6'h17, 16'hfff0, 5'd10, 5'd11));
        issue(enc_br(6'h18, 16'h0004, 5'd12, 5'd13));
        issue(enc_br(6'h1a, 16'h8000, 5'd14, 5'd15));
        issue({6'h14, 16'h1234, 10'h3ff});
        issue(enc_3r(5'h02, 5'd2, 5'd3, 5'd4));
        issue({6'h15, 16'h0040, 10'h000});
        issue(enc_3r(5'h0b, 5'd2, 5'd3, 5'd4));
        issue(enc_br(6'h13, 16'hffff, 5'd20, 5'd21));
        drain();

        test_name = "backpressure";
        bp_on = 1'b1;
        for (int i = 0; i < 60; i++) begin
            issue(random_kept());
        end
        drain();
        bp_on = 1'b0;
        ex_allowin = 1'b1;

        test_name = "r0_bypass";
        issue(enc_3r(5'h00, 5'd3, 5'd0, 5'd5));
        write_reg(5'd5, 32'h5a5a_0f0f);  // lands while add is in decode
        issue(enc_3r(5'h0a, 5'd3, 5'd5, 5'd0));
        drain();

        test_name = "ine";
        issue(32'hffff_ffff);
        issue(32'h0000_0000);
        issue(32'h3800_0000);
        issue({6'h05, 1'b1, 20'h1, 5'd2});
        drain();

        repeat (2) @(posedge clk);  // a stray late bundle still gets caught
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- tb.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/id_latch.sv
src/inst_decoder.sv
src/regfile.sv
src/operand_issue.sv
src/id_stage.sv
bench/tb_clock.sv
bench/id_stage_properties.sv
bench/tb_top.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run tb_top"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_top -Mdir obj_dir -f tb.f
	./obj_dir/Vtb_top

clean:
	rm -rf obj_dir
